//--- all.f
+incdir+include
hdl/oq_pkg.sv
hdl/oq_stream_if.sv
hdl/oq_fifo.sv
hdl/oq_distributor.sv
hdl/oq_axil_regs.sv
hdl/oq_top.sv
bench/oq_sva.sv
bench/oq_tb.sv

//--- bench/oq_sva.sv
/*
 * Concurrent checks on the output-queue stage, bound into oq_top.
 * Covers reset values, stalled stream beats, AXI-lite response hold and the
 * drop pulse. fail_count is read by the testbench for its final verdict.
 */
`timescale 1ns/10ps
`default_nettype none

`include "oq_defines.svh"

module oq_sva (
   input wire                                      axi_aclk,
   input wire                                      axi_resetn,
   input wire                                      s_axis_tready,
   input wire [`OQ_NUM_QUEUES*`OQ_DATA_WIDTH-1:0]  m_axis_tdata,
   input wire [`OQ_NUM_QUEUES-1:0]                 m_axis_tlast,
   input wire [`OQ_NUM_QUEUES-1:0]                 m_axis_tvalid,
   input wire [`OQ_NUM_QUEUES-1:0]                 m_axis_tready,
   input wire                                      s_axi_awready,
   input wire                                      s_axi_arready,
   input wire                                      s_axi_bvalid,
   input wire                                      s_axi_bready,
   input wire                                      s_axi_rvalid,
   input wire                                      s_axi_rready,
   input wire [31:0]                               s_axi_rdata,
   input wire [`OQ_NUM_QUEUES-1:0]                 drop_event
);

   int fail_count = 0;

   // Outputs idle one edge into reset
   a_reset_idle: assert property (@(posedge axi_aclk)
      !axi_resetn |=> (m_axis_tvalid == '0) && s_axis_tready && !s_axi_bvalid
                      && !s_axi_rvalid && !s_axi_awready && !s_axi_arready)
   else begin
      $error("control outputs active during reset");
      fail_count++;
   end

   for (genvar g = 0; g < `OQ_NUM_QUEUES; g++) begin : g_stall
      a_stall_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
         m_axis_tvalid[g] && !m_axis_tready[g] |=> m_axis_tvalid[g]
            && $stable(m_axis_tdata[g*`OQ_DATA_WIDTH +: `OQ_DATA_WIDTH])
            && $stable(m_axis_tlast[g]))
      else begin
         $error("stalled beat on queue %0d changed", g);
         fail_count++;
      end
   end

   a_bvalid_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
   else begin
      $error("bvalid dropped before bready");
      fail_count++;
   end

   a_rvalid_hold: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
   else begin
      $error("read response changed before rready");
      fail_count++;
   end

   a_drop_onehot: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      $onehot0(drop_event))
   else begin
      $error("drop_event has more than one bit set");
      fail_count++;
   end

endmodule

bind oq_top oq_sva u_sva (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .s_axis_tready (s_axis_tready),
   .m_axis_tdata  (m_axis_tdata),
   .m_axis_tlast  (m_axis_tlast),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .s_axi_awready (s_axi_awready),
   .s_axi_arready (s_axi_arready),
   .s_axi_bvalid  (s_axi_bvalid),
   .s_axi_bready  (s_axi_bready),
   .s_axi_rvalid  (s_axi_rvalid),
   .s_axi_rready  (s_axi_rready),
   .s_axi_rdata   (s_axi_rdata),
   .drop_event    (drop_event)
);

`default_nettype wire

//--- bench/oq_tb.sv
/*
 * Testbench of the output-queue stage. Sends random packets into the stream
 * input, models the round-robin target and the expected words of each queue,
 * and reads the drop counters over AXI-lite. Top module for all.f.
 */
`timescale 1ns/10ps
`default_nettype none

`include "oq_defines.svh"

module oq_tb;

   localparam int nq         = `OQ_NUM_QUEUES;
   localparam int dw         = `OQ_DATA_WIDTH;
   localparam int max_cycles = 4000;   // About four times the expected run

   logic             axi_aclk = 1'b0;
   logic             axi_resetn;
   logic [dw-1:0]    s_axis_tdata;
   logic             s_axis_tlast;
   logic             s_axis_tvalid;
   logic             s_axis_tready;
   logic [nq*dw-1:0] m_axis_tdata;
   logic [nq-1:0]    m_axis_tlast;
   logic [nq-1:0]    m_axis_tvalid;
   logic [nq-1:0]    m_axis_tready;
   logic [31:0]      s_axi_awaddr;
   logic             s_axi_awvalid;
   logic             s_axi_awready;
   logic [31:0]      s_axi_wdata;
   logic [3:0]       s_axi_wstrb;
   logic             s_axi_wvalid;
   logic             s_axi_wready;
   logic [1:0]       s_axi_bresp;
   logic             s_axi_bvalid;
   logic             s_axi_bready;
   logic [31:0]      s_axi_araddr;
   logic             s_axi_arvalid;
   logic             s_axi_arready;
   logic [31:0]      s_axi_rdata;
   logic [1:0]       s_axi_rresp;
   logic             s_axi_rvalid;
   logic             s_axi_rready;

   logic [dw:0]      exp_words [nq][$];   // {last, data} in delivery order
   int               sent_pkts [nq];
   int               got_pkts [nq];
   int               exp_target;          // Model of the distributor target
   int               last_q;
   int               errors;
   int               tests;
   int               tests_failed;
   int               cycles;
   bit               rand_ready;

   always #4 axi_aclk = ~axi_aclk;

   oq_top u_oq_top (.*);

   function automatic int total_errors();
      return errors + u_oq_top.u_sva.fail_count;
   endfunction

   function automatic int rand_len();
      return 1 + int'($urandom % `OQ_MAX_PKT_WORDS);
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s got %0h, expected %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   // Compares one delivered beat with the head of the model queue
   task automatic check_beat(input int q);
      logic [dw:0] exp;
      assert (exp_words[q].size() > 0) else begin
         $display("at %0t queue %0d delivered a word that was never sent to it", $time, q);
         errors++;
      end
      if (exp_words[q].size() > 0) begin
         exp = exp_words[q].pop_front();
         check_eq($sformatf("m_axis_tdata[%0d]", q), m_axis_tdata[q*dw +: dw], exp[dw-1:0]);
         check_eq($sformatf("m_axis_tlast[%0d]", q), 32'(m_axis_tlast[q]), 32'(exp[dw]));
         if (m_axis_tlast[q]) begin
            got_pkts[q]++;
         end
      end
   endtask

   always @(posedge axi_aclk) begin
      if (axi_resetn) begin
         for (int q = 0; q < nq; q++) begin
            if (m_axis_tvalid[q] && m_axis_tready[q]) begin
               check_beat(q);
            end
         end
      end
   end

   // Queue 0 always ready, the rest random
   always @(negedge axi_aclk) begin
      if (rand_ready) begin
         m_axis_tready = nq'($urandom) | nq'(1);
      end
   end

   task automatic send_packet(input int len);
      int q;
      q = exp_target;
      for (int i = 0; i < len; i++) begin
         @(negedge axi_aclk);
         s_axis_tdata  = $urandom;
         s_axis_tlast  = (i == len - 1);
         s_axis_tvalid = 1'b1;
         exp_words[q].push_back({s_axis_tlast, s_axis_tdata});
         while (!s_axis_tready) begin   // Ready only moves on the rising edge
            @(negedge axi_aclk);
         end
      end
      @(negedge axi_aclk);
      s_axis_tvalid = 1'b0;
      sent_pkts[q]++;
      exp_target = (q == last_q || q == nq - 1) ? 0 : q + 1;   // Wrap rule
   endtask

   task automatic axil_write(input logic [31:0] addr, input logic [31:0] data);
      @(negedge axi_aclk);
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
      s_axi_wdata   = data;
      s_axi_wstrb   = 4'hf;
      s_axi_wvalid  = 1'b1;
      s_axi_bready  = 1'b0;
      while (!s_axi_awready) begin
         @(negedge axi_aclk);
      end
      check_eq("s_axi_wready", 32'(s_axi_wready), 32'd1);
      @(negedge axi_aclk);
      s_axi_awvalid = 1'b0;
      s_axi_wvalid  = 1'b0;
      while (!s_axi_bvalid) begin
         @(negedge axi_aclk);
      end
      @(negedge axi_aclk);   // Response waits a cycle with bready low
      check_eq("s_axi_bresp", 32'(s_axi_bresp), 32'd0);
      s_axi_bready = 1'b1;
      @(negedge axi_aclk);
      s_axi_bready = 1'b0;
   endtask

   task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
      @(negedge axi_aclk);
      s_axi_araddr  = addr;
      s_axi_arvalid = 1'b1;
      s_axi_rready  = 1'b0;
      while (!s_axi_arready) begin
         @(negedge axi_aclk);
      end
      @(negedge axi_aclk);
      s_axi_arvalid = 1'b0;
      while (!s_axi_rvalid) begin
         @(negedge axi_aclk);
      end
      @(negedge axi_aclk);   // Read data waits a cycle with rready low
      data = s_axi_rdata;
      check_eq("s_axi_rresp", 32'(s_axi_rresp), 32'd0);
      s_axi_rready = 1'b1;
      @(negedge axi_aclk);
      s_axi_rready = 1'b0;
   endtask

   task automatic expect_reg(input logic [31:0] addr, input logic [31:0] exp, input string name);
      logic [31:0] data;
      axil_read(addr, data);
      check_eq(name, data, exp);
   endtask

   task automatic check_drop_counts(input int q0_count);
      for (int q = 0; q < nq; q++) begin
         expect_reg(`OQ_REG_DROP_BASE + 32'(4 * q), (q == 0) ? 32'(q0_count) : 32'd0,
                    $sformatf("s_axi_rdata (drop count %0d)", q));
      end
   endtask

   task automatic check_delivered();
      for (int q = 0; q < nq; q++) begin
         check_eq($sformatf("packets delivered on queue %0d", q), got_pkts[q], sent_pkts[q]);
      end
   endtask

   task automatic wait_drained();
      bit busy;
      busy = 1'b1;
      while (busy) begin
         @(negedge axi_aclk);
         busy = 1'b0;
         for (int q = 0; q < nq; q++) begin
            busy |= (exp_words[q].size() != 0);
         end
      end
   endtask

   // Quiet outputs for 8 cycles in a row
   task automatic wait_quiet();
      int idle;
      idle = 0;
      while (idle < 8) begin
         @(negedge axi_aclk);
         idle = (m_axis_tvalid == '0) ? idle + 1 : 0;
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      if (total_errors() == err_before) begin
         $display("test %0d %s: passed", tests, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: failed with %0d errors", tests, name, total_errors() - err_before);
      end
   endtask

   initial begin : watchdog
      while (cycles < max_cycles) begin
         @(posedge axi_aclk);
         cycles++;
      end
      $display("run stopped by the watchdog after %0d cycles", cycles);
      $display("Something failed");
      $finish;
   end

   initial begin : stimulus
      int err0;
      int q0_sent;
      int q0_drops;
      int idle_before;
      void'($urandom(56728));
      last_q        = nq - 1;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = '1;
      s_axi_awaddr  = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_araddr  = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      repeat (5) @(negedge axi_aclk);
      axi_resetn = 1'b1;

      err0 = total_errors();
      @(negedge axi_aclk);
      check_eq("m_axis_tvalid", 32'(m_axis_tvalid), 32'd0);
      check_eq("s_axis_tready", 32'(s_axis_tready), 32'd1);
      check_drop_counts(0);
      finish_test("reset state", err0);

      err0 = total_errors();
      for (int i = 0; i < 8; i++) begin
         send_packet(rand_len());
      end
      wait_drained();
      check_delivered();
      finish_test("round-robin", err0);

      err0 = total_errors();
      axil_write(`OQ_REG_LAST_QUEUE, 32'd1);
      last_q = 1;
      expect_reg(`OQ_REG_LAST_QUEUE, 32'd1, "s_axi_rdata (last_queue)");
      idle_before = got_pkts[2] + got_pkts[3];
      for (int i = 0; i < 6; i++) begin
         send_packet(rand_len());
      end
      wait_drained();
      check_delivered();
      check_eq("packets on queues 2 and 3", got_pkts[2] + got_pkts[3], idle_before);
      finish_test("shorter rotation", err0);

      err0 = total_errors();
      axil_write(`OQ_REG_LAST_QUEUE, 32'(nq - 1));
      last_q = nq - 1;
      @(negedge axi_aclk);
      m_axis_tready = ~nq'(1);   // Stall queue 0
      q0_sent = 0;
      while (q0_sent < 12) begin
         if (exp_target == 0) begin
            send_packet(`OQ_MAX_PKT_WORDS);
            q0_sent++;
         end else begin
            send_packet(rand_len());
         end
      end
      @(negedge axi_aclk);
      m_axis_tready = '1;
      wait_quiet();
      q0_drops = sent_pkts[0] - got_pkts[0];
      assert (q0_drops > 0) else begin
         $display("queue 0 dropped no packet while its ready was held low");
         errors++;
      end
      check_eq("words left in the queue 0 model", exp_words[0].size(),
               q0_drops * `OQ_MAX_PKT_WORDS);
      check_drop_counts(q0_drops);
      exp_words[0].delete();   // Dropped packets never arrive
      sent_pkts[0] = got_pkts[0];
      finish_test("drops", err0);

      err0 = total_errors();
      axil_write(`OQ_REG_CLEAR, 32'd1);
      check_drop_counts(0);
      finish_test("clear", err0);

      err0 = total_errors();
      @(negedge axi_aclk);
      rand_ready = 1'b1;
      for (int i = 0; i < 40; i++) begin
         while (sent_pkts[exp_target] - got_pkts[exp_target] >= 2) begin
            @(negedge axi_aclk);
         end
         send_packet(rand_len());
      end
      rand_ready = 1'b0;
      @(negedge axi_aclk);
      m_axis_tready = '1;
      wait_drained();
      check_delivered();
      check_drop_counts(0);
      finish_test("random traffic", err0);

      $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, total_errors());
      if (total_errors() == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- hdl/oq_axil_regs.sv
/*
 * AXI-lite slave of the output-queue stage. Holds the last-queue setting and
 * the per-queue drop counters, and serves reads of the register map.
 * One write and one read in flight at a time.
 */
`timescale 1ns/10ps
`default_nettype none

`include "oq_defines.svh"

module oq_axil_regs (
   input  wire                             axi_aclk,
   input  wire                             axi_resetn,
   input  wire  [31:0]                     s_axi_awaddr,
   input  wire                             s_axi_awvalid,
   output logic                            s_axi_awready,
   input  wire  [31:0]                     s_axi_wdata,
   input  wire  [3:0]                      s_axi_wstrb,
   input  wire                             s_axi_wvalid,
   output logic                            s_axi_wready,
   output logic [1:0]                      s_axi_bresp,
   output logic                            s_axi_bvalid,
   input  wire                             s_axi_bready,
   input  wire  [31:0]                     s_axi_araddr,
   input  wire                             s_axi_arvalid,
   output logic                            s_axi_arready,
   output logic [31:0]                     s_axi_rdata,
   output logic [1:0]                      s_axi_rresp,
   output logic                            s_axi_rvalid,
   input  wire                             s_axi_rready,
   input  wire  oq_pkg::queue_mask_t       drop_event,
   output logic [`OQ_QUEUE_IDX_WIDTH-1:0]  last_queue
);

   oq_pkg::drop_count_t drop_count [`OQ_NUM_QUEUES];
   logic                wr_hs;      // Address and data accepted this cycle
   logic                clear;
   logic [31:0]         rd_mux;

   assign s_axi_awready = wr_hs;
   assign s_axi_wready  = wr_hs;
   assign s_axi_bresp   = 2'b00;   // OKAY
   assign s_axi_rresp   = 2'b00;

   assign clear = wr_hs & (s_axi_awaddr == `OQ_REG_CLEAR);

   // Write channel handshake and response
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_hs        <= 1'b0;
         s_axi_bvalid <= 1'b0;
         last_queue   <= `OQ_QUEUE_IDX_WIDTH'(`OQ_NUM_QUEUES - 1);
      end else begin
         wr_hs <= s_axi_awvalid & s_axi_wvalid & ~wr_hs & ~s_axi_bvalid;
         if (wr_hs) begin
            s_axi_bvalid <= 1'b1;
         end else if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
         end
         if (wr_hs && s_axi_awaddr == `OQ_REG_LAST_QUEUE && s_axi_wstrb[0]) begin
            last_queue <= s_axi_wdata[`OQ_QUEUE_IDX_WIDTH-1:0];
         end
      end
   end

   // Clear wins over a same-cycle drop
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
            drop_count[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
            if (clear) begin
               drop_count[i] <= '0;
            end else if (drop_event[i]) begin
               drop_count[i] <= drop_count[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      rd_mux = '0;   // Clear register and holes read as zero
      if (s_axi_araddr == `OQ_REG_LAST_QUEUE) begin
         rd_mux = 32'(last_queue);
      end
      for (int i = 0; i < `OQ_NUM_QUEUES; i++) begin
         if (s_axi_araddr == `OQ_REG_DROP_BASE + 32'(4 * i)) begin
            rd_mux = drop_count[i];
         end
      end
   end

   // Read channel: arready for one cycle, rvalid on the next
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         s_axi_arready <= 1'b0;
         s_axi_rvalid  <= 1'b0;
      end else begin
         s_axi_arready <= s_axi_arvalid & ~s_axi_arready & ~s_axi_rvalid;
         if (s_axi_arready) begin
            s_axi_rvalid <= 1'b1;
         end else if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (s_axi_arready) begin
         s_axi_rdata <= rd_mux;
      end
   end

endmodule

`default_nettype wire

//--- hdl/oq_distributor.sv
/*
 * Round-robin packet distributor. Sends each whole packet from the input
 * FIFO to the current target queue, or drops it when that queue is past its
 * threshold. The rotation wraps after last_queue or after the highest queue.
 */
`timescale 1ns/10ps
`default_nettype none

`include "oq_defines.svh"

module oq_distributor (
   input  wire                                axi_aclk,
   input  wire                                axi_resetn,
   oq_stream_if.dst                           in_stream,
   oq_stream_if.src                           out_stream [`OQ_NUM_QUEUES],
   input  wire  oq_pkg::queue_mask_t          queue_full,
   input  wire  [`OQ_QUEUE_IDX_WIDTH-1:0]     last_queue,
   output oq_pkg::queue_mask_t                drop_event
);

   oq_pkg::dist_state_t state;
   oq_pkg::dist_state_t state_next;
   oq_pkg::queue_mask_t target;        // One-hot
   oq_pkg::queue_mask_t target_next;
   oq_pkg::queue_mask_t target_adv;
   oq_pkg::queue_mask_t full_q;        // Full flags, one cycle late
   logic                wrap;
   logic                write_beat;
   logic                last_beat;

   // Threshold leaves room for a whole packet, no wait on queue ready
   assign in_stream.tready = (state != oq_pkg::ST_IDLE);

   assign write_beat = (state == oq_pkg::ST_WR_PKT) & in_stream.tvalid;
   assign last_beat  = in_stream.tvalid & in_stream.tlast;

   // Wrap after the programmed last queue or the highest one
   assign wrap       = target[last_queue] | target[`OQ_NUM_QUEUES-1];
   assign target_adv = wrap ? oq_pkg::queue_mask_t'(1) : (target << 1);

   for (genvar g = 0; g < `OQ_NUM_QUEUES; g++) begin : g_out
      assign out_stream[g].tvalid = write_beat & target[g];
      assign out_stream[g].tdata  = in_stream.tdata;
      assign out_stream[g].tlast  = in_stream.tlast;
   end

   always_comb begin
      state_next  = state;
      target_next = target;
      drop_event  = '0;
      case (state)
         oq_pkg::ST_IDLE: begin
            if (in_stream.tvalid) begin
               if ((full_q & target) == '0) begin
                  state_next = oq_pkg::ST_WR_PKT;
               end else begin
                  state_next = oq_pkg::ST_DROP;
                  drop_event = target;   // Single-cycle pulse
               end
            end
         end
         oq_pkg::ST_WR_PKT,
         oq_pkg::ST_DROP: begin
            // Both states consume one beat per cycle until end of packet
            if (last_beat) begin
               state_next  = oq_pkg::ST_IDLE;
               target_next = target_adv;
            end
         end
         default: begin
            state_next = oq_pkg::ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state  <= oq_pkg::ST_IDLE;
         target <= oq_pkg::queue_mask_t'(1);   // Start at queue 0
         full_q <= '0;
      end else begin
         state  <= state_next;
         target <= target_next;
         full_q <= queue_full;
      end
   end

endmodule

`default_nettype wire

//--- hdl/oq_fifo.sv
/*
 * Fall-through FIFO for stream words. A written word is visible at the read
 * side one cycle later. Serves as input FIFO and as each output queue.
 */
`timescale 1ns/10ps
`default_nettype none

module oq_fifo #(
   parameter int depth_bits      = 2,
   parameter int prog_full_level = 3
) (
   input  wire                     axi_aclk,
   input  wire                     axi_resetn,
   input  wire                     wr_en,
   input  wire  oq_pkg::oq_word_t  wr_word,
   oq_stream_if.src                rd,
   output logic                    nearly_full,
   output logic                    prog_full
);

   localparam int depth = 1 << depth_bits;

   oq_pkg::oq_word_t      mem [depth];
   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;      // Fill level, one extra bit for full
   logic                  empty;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   assign empty = (count == '0);
   assign full  = (count == (depth_bits + 1)'(depth));
   assign do_wr = wr_en & ~full;         // Writes into a full buffer are lost
   assign do_rd = rd.tvalid & rd.tready;

   // Head word falls through to the read side
   assign rd.tvalid = ~empty;
   assign rd.tdata  = mem[rd_ptr].data;
   assign rd.tlast  = mem[rd_ptr].last;

   // One slot left
   assign nearly_full = (count >= (depth_bits + 1)'(depth - 1));
   assign prog_full   = (count >= (depth_bits + 1)'(prog_full_level));

   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_word;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous read and write keep the level
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/oq_pkg.sv
/*
 * Shared types of the output-queue stage: the stream beat, the one-hot
 * queue mask, the drop counter and the distributor states.
 * Referenced by scoped name from the modules that need them.
 */
`default_nettype none

`include "oq_defines.svh"

package oq_pkg;

   // One stream beat as stored in the FIFOs
   typedef struct packed {
      logic                      last;
      logic [`OQ_DATA_WIDTH-1:0] data;
   } oq_word_t;

   typedef logic [`OQ_NUM_QUEUES-1:0] queue_mask_t;   // One bit per queue

   typedef logic [31:0] drop_count_t;

   // Packet distributor FSM
   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_WR_PKT = 2'd1,
      ST_DROP   = 2'd2
   } dist_state_t;

endpackage

`default_nettype wire

//--- hdl/oq_stream_if.sv
/*
 * Stream link between blocks of the output-queue stage.
 * The source drives data, last and valid, the sink drives ready.
 * A beat moves on a clock edge with tvalid and tready both high.
 */
`timescale 1ns/10ps
`default_nettype none

`include "oq_defines.svh"

interface oq_stream_if;

   logic [`OQ_DATA_WIDTH-1:0] tdata;
   logic                      tlast;
   logic                      tvalid;
   logic                      tready;

   modport src (
      output tdata,
      output tlast,
      output tvalid,
      input  tready
   );

   modport dst (
      input  tdata,
      input  tlast,
      input  tvalid,
      output tready
   );

endinterface

`default_nettype wire

//--- hdl/oq_top.sv
/*
 * Output-queue stage top level. Input FIFO, round-robin distributor, one
 * FIFO per output queue and the AXI-lite register slave, all on axi_aclk.
 */
`timescale 1ns/10ps
`default_nettype none

`include "oq_defines.svh"

module oq_top (
   input  wire                                        axi_aclk,
   input  wire                                        axi_resetn,
   input  wire  [`OQ_DATA_WIDTH-1:0]                  s_axis_tdata,
   input  wire                                        s_axis_tlast,
   input  wire                                        s_axis_tvalid,
   output logic                                       s_axis_tready,
   output logic [`OQ_NUM_QUEUES*`OQ_DATA_WIDTH-1:0]   m_axis_tdata,   // Queue i at word i
   output logic [`OQ_NUM_QUEUES-1:0]                  m_axis_tlast,
   output logic [`OQ_NUM_QUEUES-1:0]                  m_axis_tvalid,
   input  wire  [`OQ_NUM_QUEUES-1:0]                  m_axis_tready,
   input  wire  [31:0]                                s_axi_awaddr,
   input  wire                                        s_axi_awvalid,
   output logic                                       s_axi_awready,
   input  wire  [31:0]                                s_axi_wdata,
   input  wire  [3:0]                                 s_axi_wstrb,
   input  wire                                        s_axi_wvalid,
   output logic                                       s_axi_wready,
   output logic [1:0]                                 s_axi_bresp,
   output logic                                       s_axi_bvalid,
   input  wire                                        s_axi_bready,
   input  wire  [31:0]                                s_axi_araddr,
   input  wire                                        s_axi_arvalid,
   output logic                                       s_axi_arready,
   output logic [31:0]                                s_axi_rdata,
   output logic [1:0]                                 s_axi_rresp,
   output logic                                       s_axi_rvalid,
   input  wire                                        s_axi_rready
);

   oq_pkg::oq_word_t                 in_word;
   logic                             in_nearly_full;
   oq_pkg::queue_mask_t              queue_full;
   oq_pkg::queue_mask_t              drop_event;
   logic [`OQ_QUEUE_IDX_WIDTH-1:0]   last_queue;
   logic [`OQ_NUM_QUEUES-1:0]        q_nearly_full;
   oq_pkg::oq_word_t                 q_word [`OQ_NUM_QUEUES];

   oq_stream_if in_rd ();
   oq_stream_if dist_out [`OQ_NUM_QUEUES] ();
   oq_stream_if q_out [`OQ_NUM_QUEUES] ();

   assign in_word       = '{last: s_axis_tlast, data: s_axis_tdata};
   assign s_axis_tready = ~in_nearly_full;

   oq_fifo #(
      .depth_bits      (`OQ_IN_DEPTH_BITS),
      .prog_full_level (1 << `OQ_IN_DEPTH_BITS)
   ) u_in_fifo (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (s_axis_tvalid & s_axis_tready),
      .wr_word     (in_word),
      .rd          (in_rd),
      .nearly_full (in_nearly_full),
      .prog_full   ()
   );

   oq_distributor u_dist (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn),
      .in_stream  (in_rd),
      .out_stream (dist_out),
      .queue_full (queue_full),
      .last_queue (last_queue),
      .drop_event (drop_event)
   );

   for (genvar g = 0; g < `OQ_NUM_QUEUES; g++) begin : g_queue
      assign q_word[g]          = '{last: dist_out[g].tlast, data: dist_out[g].tdata};
      assign dist_out[g].tready = ~q_nearly_full[g];

      oq_fifo #(
         .depth_bits      (`OQ_OUT_DEPTH_BITS),
         .prog_full_level (`OQ_PROG_FULL_LEVEL)
      ) u_out_fifo (
         .axi_aclk    (axi_aclk),
         .axi_resetn  (axi_resetn),
         .wr_en       (dist_out[g].tvalid),
         .wr_word     (q_word[g]),
         .rd          (q_out[g]),
         .nearly_full (q_nearly_full[g]),
         .prog_full   (queue_full[g])
      );

      assign m_axis_tdata[g*`OQ_DATA_WIDTH +: `OQ_DATA_WIDTH] = q_out[g].tdata;
      assign m_axis_tlast[g]  = q_out[g].tlast;
      assign m_axis_tvalid[g] = q_out[g].tvalid;
      assign q_out[g].tready  = m_axis_tready[g];
   end

   oq_axil_regs u_regs (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wdata   (s_axi_wdata),
      .s_axi_wstrb   (s_axi_wstrb),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bresp   (s_axi_bresp),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .drop_event    (drop_event),
      .last_queue    (last_queue)
   );

endmodule

`default_nettype wire

//--- include/oq_defines.svh
/*
 * Sizes, thresholds and register offsets of the output-queue stage.
 * Included by the package, the stream interface and the RTL modules.
 */
`ifndef OQ_DEFINES_SVH
`define OQ_DEFINES_SVH

// Stream word and queue count
`define OQ_DATA_WIDTH       32
`define OQ_NUM_QUEUES       4
`define OQ_QUEUE_IDX_WIDTH  2

// FIFO depths as log2
`define OQ_IN_DEPTH_BITS    2
`define OQ_OUT_DEPTH_BITS   4   // 16 words per output queue

// Longest legal packet in words
`define OQ_MAX_PKT_WORDS    4

// Leaves room for one maximum packet above the threshold
`define OQ_PROG_FULL_LEVEL  ((1 << `OQ_OUT_DEPTH_BITS) - `OQ_MAX_PKT_WORDS)

// AXI-lite register map
`define OQ_REG_LAST_QUEUE   32'h0000_0000
`define OQ_REG_CLEAR        32'h0000_0004
`define OQ_REG_DROP_BASE    32'h0000_0010   // Drop count i at base + 4*i

`endif

//--- run_sim.sh
#!/bin/sh
# Builds the output-queue testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module oq_tb

# Assertion errors must not stop the run before the testbench verdict
out=$(./obj_dir/Voq_tb +verilator+error+limit+1000 || true)
echo "$out"
echo "$out" | grep -qx "Everything OK"
